/* hw/datapathPkg.sv */
package datapathPkg;

    localparam int wordWidth = 32;  // bus and register width
    localparam int regCount = 16;   // general registers R0..R15

    // 5-bit ALU function codes
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opShr  = 5'b00101,
        opShra = 5'b00110,
        opShl  = 5'b00111,
        opRor  = 5'b01000,
        opRol  = 5'b01001,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opMul  = 5'b01111,
        opDiv  = 5'b10000,
        opNeg  = 5'b10001,
        opNot  = 5'b10010
    } aluOp;

    typedef struct packed {
        logic [wordWidth-1:0] high;  // ZHigh holds the remainder after div
        logic [wordWidth-1:0] low;   // ZLow holds the quotient after div
    } zHalves;

    // Z is written whole by mul and read back as two bus words
    typedef union packed {
        logic [2*wordWidth-1:0] full;
        zHalves halves;
    } zWord;

endpackage

/* hw/registerFile.sv */
`timescale 1ns/1ps

module registerFile #(
    parameter int DataWidth = datapathPkg::wordWidth,
    parameter int RegCount = datapathPkg::regCount
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [DataWidth-1:0] busData,
    input  logic [RegCount-1:0]  regEnable,
    output logic [DataWidth-1:0] regValues [RegCount]
);

    // every enabled register takes the bus word, so R-to-R copies can fan out
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regValues[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RegCount; i++) begin
                if (regEnable[i]) begin
                    regValues[i] <= busData;
                end
            end
        end
    end

endmodule

/* hw/busMux.sv */
`timescale 1ns/1ps

module busMux #(
    parameter int DataWidth = datapathPkg::wordWidth,
    parameter int RegCount = datapathPkg::regCount
) (
    input  logic [DataWidth-1:0] regValues [RegCount],
    input  logic [DataWidth-1:0] pcValue,
    input  logic [DataWidth-1:0] mdrValue,
    input  logic [DataWidth-1:0] zHigh,
    input  logic [DataWidth-1:0] zLow,
    input  logic [DataWidth-1:0] hiValue,
    input  logic [DataWidth-1:0] loValue,
    input  logic [RegCount-1:0]  regOut,
    input  logic                 pcOut,
    input  logic                 mdrOut,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    input  logic                 hiOut,
    input  logic                 loOut,
    output logic [DataWidth-1:0] busData
);

    localparam int SrcCount = RegCount + 6;
    localparam int SelWidth = $clog2(SrcCount);
    localparam int RegIdxWidth = $clog2(RegCount);

    // source numbers above the general registers
    localparam logic [SelWidth-1:0] PcSel = SelWidth'(RegCount);
    localparam logic [SelWidth-1:0] MdrSel = SelWidth'(RegCount + 1);
    localparam logic [SelWidth-1:0] ZHighSel = SelWidth'(RegCount + 2);
    localparam logic [SelWidth-1:0] ZLowSel = SelWidth'(RegCount + 3);
    localparam logic [SelWidth-1:0] HiSel = SelWidth'(RegCount + 4);
    localparam logic [SelWidth-1:0] LoSel = SelWidth'(RegCount + 5);

    logic [SrcCount-1:0] strobes;
    logic [SelWidth-1:0] srcSel;
    logic                srcValid;

    assign strobes = {loOut, hiOut, zLowOut, zHighOut, mdrOut, pcOut, regOut};

    // scan downward so the lowest set strobe is the one left standing
    always_comb begin
        srcSel = '0;
        srcValid = 1'b0;
        for (int i = SrcCount - 1; i >= 0; i--) begin
            if (strobes[i]) begin
                srcSel = SelWidth'(i);
                srcValid = 1'b1;
            end
        end
    end

    always_comb begin
        busData = '0;  // idle bus reads zero
        if (srcValid) begin
            case (srcSel)
                PcSel:    busData = pcValue;
                MdrSel:   busData = mdrValue;
                ZHighSel: busData = zHigh;
                ZLowSel:  busData = zLow;
                HiSel:    busData = hiValue;
                LoSel:    busData = loValue;
                default:  busData = regValues[srcSel[RegIdxWidth-1:0]];  // R0..R15
            endcase
        end
    end

endmodule

/* hw/boothMultiplier.sv */
`timescale 1ns/1ps

module boothMultiplier #(
    parameter int DataWidth = datapathPkg::wordWidth
) (
    input  logic [DataWidth-1:0]   multiplicand,
    input  logic [DataWidth-1:0]   multiplier,
    output logic [2*DataWidth-1:0] product
);

    localparam int DigitCount = DataWidth / 2;
    localparam int ProdWidth = 2 * DataWidth;

    logic signed [ProdWidth-1:0] mcandExt;
    logic [DataWidth:0]          mplierExt;
    logic signed [ProdWidth-1:0] partials [DigitCount];

    assign mcandExt = {{DataWidth{multiplicand[DataWidth-1]}}, multiplicand};
    assign mplierExt = {multiplier, 1'b0};  // implicit bit below the lsb

    // one radix-4 digit per bit pair from bits 2i+1 down to 2i-1
    for (genvar i = 0; i < DigitCount; i++) begin : gDigit
        logic [2:0] digitBits;
        logic signed [ProdWidth-1:0] scaled;

        assign digitBits = mplierExt[2*i +: 3];

        always_comb begin
            case (digitBits)
                3'b001, 3'b010: scaled = mcandExt;          // +1
                3'b011:         scaled = mcandExt <<< 1;    // +2
                3'b100:         scaled = -(mcandExt <<< 1); // -2
                3'b101, 3'b110: scaled = -mcandExt;         // -1
                default:        scaled = '0;
            endcase
        end

        assign partials[i] = scaled <<< (2 * i);
    end

    // the top digit uses the multiplier sign bit, which makes the sum signed
    always_comb begin
        logic signed [ProdWidth-1:0] sum;
        sum = '0;
        for (int i = 0; i < DigitCount; i++) begin
            sum = sum + partials[i];
        end
        product = sum;
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int DataWidth = datapathPkg::wordWidth
) (
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  datapathPkg::aluOp    opcode,
    output datapathPkg::zWord    result
);

    import datapathPkg::*;

    localparam int ShiftWidth = $clog2(DataWidth);

    logic [ShiftWidth-1:0]         shiftAmt;
    logic [2*DataWidth-1:0]        rotRight;
    logic [2*DataWidth-1:0]        rotLeft;
    logic [2*DataWidth-1:0]        product;
    logic signed [DataWidth-1:0]   divisor;
    logic signed [DataWidth-1:0]   quotient;
    logic signed [DataWidth-1:0]   remainder;
    logic [DataWidth-1:0]          lowWord;
    logic [DataWidth-1:0]          highWord;

    assign shiftAmt = b[ShiftWidth-1:0];  // amount is taken mod 32

    // rotate by shifting a doubled copy of a
    assign rotRight = {a, a} >> shiftAmt;
    assign rotLeft = {a, a} << shiftAmt;

    boothMultiplier #(
        .DataWidth(DataWidth)
    ) uMult (
        .multiplicand(a),
        .multiplier(b),
        .product(product)
    );

    // a zero divisor becomes one so the division stays defined
    assign divisor = (b == '0) ? DataWidth'(1) : $signed(b);
    assign quotient = $signed(a) / divisor;   // truncates toward zero
    assign remainder = $signed(a) % divisor;  // sign follows a

    always_comb begin
        lowWord = '0;
        highWord = '0;
        case (opcode)
            opAdd:  lowWord = a + b;
            opSub:  lowWord = a - b;
            opShr:  lowWord = a >> shiftAmt;
            opShra: lowWord = DataWidth'($signed(a) >>> shiftAmt);
            opShl:  lowWord = a << shiftAmt;
            opRor:  lowWord = rotRight[DataWidth-1:0];
            opRol:  lowWord = rotLeft[2*DataWidth-1:DataWidth];
            opAnd:  lowWord = a & b;
            opOr:   lowWord = a | b;
            opNeg:  lowWord = -b;
            opNot:  lowWord = ~b;
            opDiv: begin
                if (b == '0) begin
                    lowWord = '1;
                    highWord = a;
                end else begin
                    lowWord = quotient;
                    highWord = remainder;
                end
            end
            default: ;  // mul is taken from the product below
        endcase
        // arithmetic results carry their sign into ZHigh
        if (opcode inside {opAdd, opSub, opNeg}) begin
            highWord = {DataWidth{lowWord[DataWidth-1]}};
        end
    end

    always_comb begin
        if (opcode == opMul) begin
            result.full = product;
        end else begin
            result.halves.high = highWord;
            result.halves.low = lowWord;
        end
    end

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath #(
    parameter int DataWidth = datapathPkg::wordWidth,
    parameter int RegCount = datapathPkg::regCount
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [DataWidth-1:0] mDataIn,
    input  logic                 Read,
    input  logic                 mdrEnable,
    input  logic                 marEnable,
    input  logic                 pcEnable,
    input  logic                 incPc,
    input  logic                 irEnable,
    input  logic                 yEnable,
    input  logic                 zEnable,
    input  logic                 hiEnable,
    input  logic                 loEnable,
    input  logic [RegCount-1:0]  regEnable,
    input  logic [RegCount-1:0]  regOut,
    input  logic                 pcOut,
    input  logic                 mdrOut,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  datapathPkg::aluOp    opcode,
    output logic [DataWidth-1:0] busData,
    output logic [DataWidth-1:0] marAddr,
    output logic [DataWidth-1:0] irWord
);

    import datapathPkg::*;

    logic [DataWidth-1:0] regValues [RegCount];
    logic [DataWidth-1:0] pcReg;
    logic [DataWidth-1:0] irReg;
    logic [DataWidth-1:0] marReg;
    logic [DataWidth-1:0] mdrReg;
    logic [DataWidth-1:0] yReg;
    logic [DataWidth-1:0] hiReg;
    logic [DataWidth-1:0] loReg;
    zWord                 zReg;
    zWord                 aluResult;
    logic [DataWidth-1:0] mdrNext;
    logic [DataWidth-1:0] pcNext;

    assign mdrNext = Read ? mDataIn : busData;            // memory side or bus side
    assign pcNext = incPc ? pcReg + DataWidth'(1) : busData;  // increment wins over a bus load

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcReg <= '0;
            irReg <= '0;
            marReg <= '0;
            mdrReg <= '0;
            yReg <= '0;
            zReg <= '0;
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (pcEnable) pcReg <= pcNext;
            if (irEnable) irReg <= busData;
            if (marEnable) marReg <= busData;
            if (mdrEnable) mdrReg <= mdrNext;
            if (yEnable) yReg <= busData;
            if (zEnable) zReg <= aluResult;  // ALU output is ready in the same cycle
            if (hiEnable) hiReg <= busData;
            if (loEnable) loReg <= busData;
        end
    end

    assign marAddr = marReg;
    assign irWord = irReg;

    registerFile #(
        .DataWidth(DataWidth),
        .RegCount(RegCount)
    ) uRegs (
        .Clock(Clock),
        .rstN(rstN),
        .busData(busData),
        .regEnable(regEnable),
        .regValues(regValues)
    );

    busMux #(
        .DataWidth(DataWidth),
        .RegCount(RegCount)
    ) uBus (
        .regValues(regValues),
        .pcValue(pcReg),
        .mdrValue(mdrReg),
        .zHigh(zReg.halves.high),
        .zLow(zReg.halves.low),
        .hiValue(hiReg),
        .loValue(loReg),
        .regOut(regOut),
        .pcOut(pcOut),
        .mdrOut(mdrOut),
        .zHighOut(zHighOut),
        .zLowOut(zLowOut),
        .hiOut(hiOut),
        .loOut(loOut),
        .busData(busData)
    );

    // Y feeds the A side and the bus feeds the B side
    alu #(
        .DataWidth(DataWidth)
    ) uAlu (
        .a(yReg),
        .b(busData),
        .opcode(opcode),
        .result(aluResult)
    );

endmodule

/* sim/datapathProperties.sv */
`timescale 1ns/1ps

module datapathProperties #(
    parameter int DataWidth = datapathPkg::wordWidth,
    parameter int RegCount = datapathPkg::regCount
) (
    input logic                 Clock,
    input logic                 rstN,
    input logic [RegCount-1:0]  regOut,
    input logic                 pcOut,
    input logic                 mdrOut,
    input logic                 zHighOut,
    input logic                 zLowOut,
    input logic                 hiOut,
    input logic                 loOut,
    input logic [DataWidth-1:0] busData,
    input logic                 pcEnable,
    input logic                 incPc,
    input logic [DataWidth-1:0] pcReg
);

    logic [RegCount+5:0] strobes;

    assign strobes = {loOut, hiOut, zLowOut, zHighOut, mdrOut, pcOut, regOut};

    // the mux resolves collisions by priority, which would hide a sequencing bug
    singleDriver: assert property (@(posedge Clock) disable iff (!rstN) $onehot0(strobes))
        else $error("more than one bus source strobe is high");

    resetBusZero: assert property (@(posedge Clock) !rstN |-> busData == '0)
        else $error("bus is not zero while reset is asserted");

    pcStep: assert property (@(posedge Clock) disable iff (!rstN)
        pcEnable && incPc |=> pcReg == $past(pcReg) + DataWidth'(1))
        else $error("PC did not advance by one on an increment cycle");

endmodule

bind datapath datapathProperties #(
    .DataWidth(DataWidth),
    .RegCount(RegCount)
) uProps (.*);

/* sim/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb;

    import datapathPkg::*;

    localparam int DataWidth = wordWidth;
    localparam int RegCount = regCount;
    localparam int VecWords = 5;  // opcode, A, B, high, low
    localparam int MaxVectors = 64;
    localparam int SrcPc = RegCount;  // bus source codes above the general registers
    localparam int SrcMdr = RegCount + 1;
    localparam int SrcHi = RegCount + 4;
    localparam int SrcLo = RegCount + 5;

    logic                 Clock;
    logic                 rstN;
    logic [DataWidth-1:0] mDataIn;
    logic                 Read, mdrEnable, marEnable, pcEnable, incPc, irEnable;
    logic                 yEnable, zEnable, hiEnable, loEnable;
    logic [RegCount-1:0]  regEnable;
    logic [RegCount-1:0]  regOut;
    logic                 pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut;
    aluOp                 opcode;
    logic [DataWidth-1:0] busData;
    logic [DataWidth-1:0] marAddr;
    logic [DataWidth-1:0] irWord;

    logic [DataWidth-1:0] golden [MaxVectors*VecWords];
    int vectorCount = 0;
    int cycleCount = 0;
    int cycleLimit = 200;
    int errorCount = 0;
    int testErrors = 0;
    int failedTests = 0;
    int testNum = 1;

    datapath #(.DataWidth(DataWidth), .RegCount(RegCount)) UUT (.*);

    always #50 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the sequence never reached its end", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [RegCount-1:0] oneHot(input int idx);
        return RegCount'(1) << idx;
    endfunction

    function automatic logic [DataWidth-1:0] regPattern(input int idx);
        return 32'hC0DE_0000 | DataWidth'(idx * 257 + 1);  // distinct per register
    endfunction

    // every sequencer step starts at a rising edge with all strobes dropped
    task automatic startCycle();
        @(posedge Clock);
        {Read, mdrEnable, marEnable, pcEnable, incPc, irEnable} <= '0;
        {yEnable, zEnable, hiEnable, loEnable} <= '0;
        {pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut} <= '0;
        regEnable <= '0;
        regOut <= '0;
        mDataIn <= '0;
    endtask

    task automatic applyReset();
        startCycle();
        rstN <= 1'b0;
        repeat (8) @(posedge Clock);
        rstN <= 1'b1;
    endtask

    task automatic driveSource(input int src);
        case (src)
            SrcPc:   pcOut <= 1'b1;
            SrcMdr:  mdrOut <= 1'b1;
            SrcHi:   hiOut <= 1'b1;
            SrcLo:   loOut <= 1'b1;
            default: regOut <= oneHot(src);
        endcase
    endtask

    task automatic readSource(input int src, output logic [DataWidth-1:0] value);
        startCycle();
        driveSource(src);
        @(negedge Clock);  // sample mid cycle after the bus settles
        value = busData;
    endtask

    task automatic loadMdr(input logic [DataWidth-1:0] value);
        startCycle();
        mDataIn <= value;
        Read <= 1'b1;
        mdrEnable <= 1'b1;
    endtask

    task automatic loadRegister(input int idx, input logic [DataWidth-1:0] value);
        loadMdr(value);
        startCycle();
        mdrOut <= 1'b1;
        regEnable <= oneHot(idx);
    endtask

    task automatic reportMismatch(input string what, input logic [DataWidth-1:0] got,
                                  input logic [DataWidth-1:0] expected);
        $display("FAIL %0d ns: %s read %h, expected %h", $time, what, got, expected);
        errorCount += 1;
        testErrors += 1;
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("test %0d %s: ok", testNum, name);
        end else begin
            $display("test %0d %s: %0d mismatches", testNum, name, testErrors);
            failedTests += 1;
        end
        testNum += 1;
        testErrors = 0;
    endtask

    task automatic checkSourcesZero(input string name);
        int srcs [5] = '{SrcPc, SrcMdr, SrcHi, SrcLo, 0};
        logic [DataWidth-1:0] value;
        foreach (srcs[i]) begin
            readSource(srcs[i], value);
            if (value !== '0) begin
                reportMismatch($sformatf("source %0d after reset", srcs[i]), value, '0);
            end
        end
        finishTest(name);
    endtask

    task automatic checkRegisters();
        logic [DataWidth-1:0] value;
        for (int i = 0; i < RegCount; i++) begin
            loadRegister(i, regPattern(i));
            readSource(i, value);
            if (value !== regPattern(i)) begin
                reportMismatch($sformatf("R%0d after load", i), value, regPattern(i));
            end
        end
        for (int i = 0; i < RegCount; i++) begin  // later loads leave earlier ones alone
            readSource(i, value);
            if (value !== regPattern(i)) begin
                reportMismatch($sformatf("R%0d at final readback", i), value, regPattern(i));
            end
        end
        finishTest("general registers");
    endtask

    task automatic runAluVectors();
        logic [DataWidth-1:0] lo;
        logic [DataWidth-1:0] hi;
        int base;
        for (int n = 0; n < vectorCount; n++) begin
            base = n * VecWords;
            loadRegister(6, golden[base+1]);
            loadRegister(7, golden[base+2]);
            startCycle();
            regOut <= oneHot(6);
            yEnable <= 1'b1;
            startCycle();
            regOut <= oneHot(7);
            opcode <= aluOp'(golden[base][4:0]);
            zEnable <= 1'b1;
            startCycle();
            zLowOut <= 1'b1;
            loEnable <= 1'b1;
            startCycle();
            zHighOut <= 1'b1;
            hiEnable <= 1'b1;
            readSource(SrcLo, lo);
            readSource(SrcHi, hi);
            if (lo !== golden[base+4]) begin
                reportMismatch($sformatf("vector %0d low word", n), lo, golden[base+4]);
            end
            if (hi !== golden[base+3]) begin
                reportMismatch($sformatf("vector %0d high word", n), hi, golden[base+3]);
            end
        end
        finishTest("ALU golden vectors");
    endtask

    task automatic checkPcIncrement();
        logic [DataWidth-1:0] value;
        for (int k = 1; k <= 3; k++) begin
            startCycle();
            pcEnable <= 1'b1;
            incPc <= 1'b1;
            readSource(SrcPc, value);
            if (value !== DataWidth'(k)) begin
                reportMismatch($sformatf("PC after %0d increments", k), value, DataWidth'(k));
            end
        end
        loadMdr(32'h0000_7FFF);
        startCycle();
        mdrOut <= 1'b1;
        pcEnable <= 1'b1;
        startCycle();
        pcEnable <= 1'b1;
        incPc <= 1'b1;
        readSource(SrcPc, value);
        if (value !== 32'h0000_8000) begin
            reportMismatch("PC after bus load and increment", value, 32'h0000_8000);
        end
        finishTest("PC increment");
    endtask

    task automatic checkCaptures();
        logic [DataWidth-1:0] value;
        startCycle();
        regOut <= oneHot(4);
        marEnable <= 1'b1;
        startCycle();
        regOut <= oneHot(9);
        irEnable <= 1'b1;
        startCycle();
        regOut <= oneHot(11);
        mdrEnable <= 1'b1;
        mDataIn <= 32'hDEAD_BEEF;  // must be ignored with Read low
        @(negedge Clock);
        if (marAddr !== regPattern(4)) begin
            reportMismatch("marAddr", marAddr, regPattern(4));
        end
        if (irWord !== regPattern(9)) begin
            reportMismatch("irWord", irWord, regPattern(9));
        end
        readSource(SrcMdr, value);
        if (value !== regPattern(11)) begin
            reportMismatch("MDR loaded from bus", value, regPattern(11));
        end
        finishTest("MAR, IR and MDR capture");
    endtask

    task automatic checkMidRunReset();
        int srcs [3] = '{SrcHi, SrcLo, 3};
        logic [DataWidth-1:0] value;
        loadMdr(32'hA5A5_0001);
        startCycle();
        mdrOut <= 1'b1;
        hiEnable <= 1'b1;
        loadMdr(32'h5A5A_0002);
        startCycle();
        mdrOut <= 1'b1;
        loEnable <= 1'b1;
        applyReset();
        foreach (srcs[i]) begin
            readSource(srcs[i], value);
            if (value !== '0) begin
                reportMismatch($sformatf("source %0d after mid-run reset", srcs[i]), value, '0);
            end
        end
        finishTest("mid-run reset");
    endtask

    initial begin
        Clock = 1'b0;
        rstN = 1'b1;
        mDataIn = '0;
        {Read, mdrEnable, marEnable, pcEnable, incPc, irEnable} = '0;
        {yEnable, zEnable, hiEnable, loEnable} = '0;
        {pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut} = '0;
        regEnable = '0;
        regOut = '0;
        opcode = opAdd;
        foreach (golden[i]) begin
            golden[i] = '1;  // marks words the file does not fill
        end
        $readmemh("sim/datapathGolden.mem", golden);
        while (vectorCount < MaxVectors && golden[vectorCount*VecWords] != '1) begin
            vectorCount += 1;
        end
        if (vectorCount == 0) begin
            $display("no test vectors were found in the golden file");
            errorCount += 1;
        end
        cycleLimit = 40 * vectorCount + 200;
        applyReset();
        checkSourcesZero("bus after reset");
        checkRegisters();
        runAluVectors();
        checkPcIncrement();
        checkCaptures();
        checkMidRunReset();
        $display("tests %0d, failing tests %0d, mismatches %0d, vectors %0d",
                 testNum - 1, failedTests, errorCount, vectorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/datapathPkg.sv
hw/registerFile.sv
hw/busMux.sv
hw/boothMultiplier.sv
hw/alu.sv
hw/datapath.sv
sim/datapathProperties.sv
sim/datapathTb.sv

/* run.sh */
#!/bin/sh
# build the datapath testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
    --top-module datapathTb -o simDatapath > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/simDatapath > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* sim/datapathGolden.mem */
// ALU vectors, one per line: opcode A B expectedHigh expectedLow (all hex)
// opcode uses the aluOp encoding, A goes through Y and B comes from the bus
00000003 00000005 00000003 00000000 00000008
00000003 7fffffff 00000001 ffffffff 80000000
00000004 00000003 00000005 ffffffff fffffffe
00000004 12345678 02345678 00000000 10000000
00000004 80000000 00000001 00000000 7fffffff
00000005 f0000000 00000004 00000000 0f000000
00000006 f0000000 00000004 00000000 ff000000
00000007 0000000f 00000024 00000000 000000f0
00000008 00000001 00000001 00000000 80000000
00000008 12345678 00000008 00000000 78123456
00000009 80000001 00000004 00000000 00000018
0000000a f0f0f0f0 ff00ff00 00000000 f000f000
0000000b f0f0f0f0 0f0f0000 00000000 fffff0f0
0000000f 00000007 00000006 00000000 0000002a
0000000f fffffffd 00000005 ffffffff fffffff1
0000000f 80000000 80000000 40000000 00000000
0000000f 00010000 00010000 00000001 00000000
0000000f ffffffff ffffffff 00000000 00000001
00000010 00000011 00000005 00000002 00000003
00000010 ffffffef 00000005 fffffffe fffffffd
00000010 00000011 fffffffb 00000002 fffffffd
00000010 00000064 00000000 00000064 ffffffff
00000011 00000000 00000005 ffffffff fffffffb
00000011 00000000 ffffffff 00000000 00000001
00000012 00000000 0000ffff 00000000 ffff0000
